// File: source/rename_pkg.sv
package rename_pkg;

	// ----------------------------------------
	// Datapath and architectural registers
	// ----------------------------------------
	localparam int xlen = 64;
	localparam int arch_w = 5;   // x0..x31

	// ----------------------------------------
	// Renaming
	// ----------------------------------------
	// Each architectural register owns 2**rb physical copies
	localparam int rb = 2;
	localparam int phys_tag_w = arch_w + rb;
	localparam int phys_cnt = 2 ** phys_tag_w;

	// arch of zero is x0, any version
	typedef struct packed {
		logic [arch_w-1:0] arch;
		logic [rb-1:0] version;
	} phys_tag_t;

endpackage

// File: source/jal_pkg.sv
package jal_pkg;

	import rename_pkg::*;

	localparam int jal_dp = 4;   // Issue buffer slots
	localparam int jal_idx_w = $clog2(jal_dp);

	// ----------------------------------------
	// Issue buffer entry
	// ----------------------------------------
	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		logic [xlen-1:0] pc;
		phys_tag_t rd;
		phys_tag_t rs1;
		logic is_rvc;   // 16-bit encoding
	} jal_info_t;

	// Operands latched at issue
	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		phys_tag_t rd;
		logic [xlen-1:0] src1;
		logic [xlen-1:0] pc;
		logic is_rvc;
	} jal_exeparam_t;

	// ----------------------------------------
	// Execute result, doubles as write-back
	// ----------------------------------------
	typedef struct packed {
		phys_tag_t rd;
		logic [xlen-1:0] link;
		logic redirect;   // jalr only
		logic [xlen-1:0] target;
	} jal_result_t;

endpackage

// File: source/issue_buffer.sv
module issue_buffer import jal_pkg::*; #(
	parameter type payload_t = jal_info_t,
	parameter int depth = jal_dp
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic dispatch_valid,
	input  payload_t dispatch_info,
	output logic credit_return,
	input  logic pop,
	input  logic [$clog2(depth)-1:0] pop_index,
	output logic [depth-1:0] entry_valid,
	output payload_t entries [depth]
);

	typedef logic [$clog2(depth)-1:0] idx_t;
	typedef logic [$clog2(depth+1)-1:0] cnt_t;

	idx_t free_idx;
	cnt_t ret_add;
	cnt_t ret_total;
	cnt_t pend_cnt;   // Credits still owed to dispatch

	// Lowest free slot, sender holds a credit so one exists
	always_comb begin
		free_idx = '0;
		for (int i = depth - 1; i >= 0; i--) begin
			if (!entry_valid[i]) begin
				free_idx = i[$clog2(depth)-1:0];
			end
		end
	end

	// ----------------------------------------
	// Credit return queue
	// ----------------------------------------
	always_comb begin
		ret_add = '0;
		if (flush) begin
			for (int i = 0; i < depth; i++) begin
				ret_add = ret_add + cnt_t'(entry_valid[i]);
			end
			ret_add = ret_add + cnt_t'(dispatch_valid);   // Dropped dispatch
		end else begin
			ret_add = cnt_t'(pop);
		end
	end

	assign ret_total = pend_cnt + ret_add;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pend_cnt <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= (ret_total != '0);
			if (ret_total != '0) begin
				pend_cnt <= ret_total - cnt_t'(1);   // One pulse per cycle
			end else begin
				pend_cnt <= '0;
			end
		end
	end

	// ----------------------------------------
	// Slots
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			entry_valid <= '0;
		end else if (flush) begin
			entry_valid <= '0;
		end else begin
			if (pop) begin
				entry_valid[pop_index] <= 1'b0;
			end
			if (dispatch_valid) begin
				entry_valid[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (dispatch_valid && !flush) begin
			entries[free_idx] <= dispatch_info;
		end
	end

endmodule

// File: source/jal_issue.sv
module jal_issue import rename_pkg::*, jal_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic [jal_dp-1:0] entry_valid,
	input  jal_info_t entries [jal_dp],
	output logic pop,
	output logic [jal_idx_w-1:0] pop_index,
	output phys_tag_t rs1_tags [jal_dp],
	input  logic [xlen-1:0] rs1_data [jal_dp],
	input  logic [jal_dp-1:0] rs1_ready,
	output logic exeparam_valid,
	output jal_exeparam_t exeparam
);

	logic [jal_dp-1:0] clear_raw;
	logic [jal_dp-1:0] rs1_is_x0;

	// ----------------------------------------
	// Operand readiness per slot
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < jal_dp; i++) begin
			rs1_tags[i] = entries[i].rs1;
			rs1_is_x0[i] = (entries[i].rs1.arch == '0);
			// jal has no source, jalr waits on rs1
			clear_raw[i] = entry_valid[i] & (entries[i].is_jal
				| (entries[i].is_jalr & (rs1_ready[i] | rs1_is_x0[i])));
		end
	end

	// Lowest index wins
	always_comb begin
		pop_index = '0;
		for (int i = jal_dp - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				pop_index = i[jal_idx_w-1:0];
			end
		end
	end

	assign pop = (|clear_raw) & ~flush;

	// ----------------------------------------
	// Execute parameter register
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= pop;   // Low on flush too
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exeparam.is_jal <= entries[pop_index].is_jal;
			exeparam.is_jalr <= entries[pop_index].is_jalr;
			exeparam.rd <= entries[pop_index].rd;
			exeparam.src1 <= rs1_data[pop_index];
			exeparam.pc <= entries[pop_index].pc;
			exeparam.is_rvc <= entries[pop_index].is_rvc;
		end
	end

endmodule

// File: source/jal_execute.sv
module jal_execute import rename_pkg::*, jal_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic exeparam_valid,
	input  jal_exeparam_t exeparam,
	output logic result_valid,
	output jal_result_t result
);

	logic is_jump;
	logic [xlen-1:0] link_nxt;
	logic [xlen-1:0] target_nxt;

	assign is_jump = exeparam_valid & (exeparam.is_jal | exeparam.is_jalr);

	// Return address past this instruction
	assign link_nxt = exeparam.pc + (exeparam.is_rvc ? xlen'(2) : xlen'(4));

	// No immediate in this slice
	assign target_nxt = exeparam.is_jalr ? {exeparam.src1[xlen-1:1], 1'b0} : '0;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= is_jump;
		end
	end

	always_ff @(posedge CLK) begin
		if (is_jump) begin
			result.rd <= exeparam.rd;
			result.link <= link_nxt;
			result.redirect <= exeparam.is_jalr;
			result.target <= target_nxt;
		end
	end

endmodule

// File: source/phy_regfile.sv
module phy_regfile import rename_pkg::*, jal_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  phys_tag_t rs1_tags [jal_dp],
	output logic [xlen-1:0] rs1_data [jal_dp],
	output logic [jal_dp-1:0] rs1_ready,
	input  logic wb_valid,
	input  phys_tag_t wb_tag,
	input  logic [xlen-1:0] wb_data,
	input  logic ext_wb_valid,
	input  phys_tag_t ext_wb_tag,
	input  logic [xlen-1:0] ext_wb_data
);

	logic [xlen-1:0] regs [phys_cnt];
	logic [phys_cnt-1:0] wb_log;   // One ready bit per tag
	logic exe_we;
	logic ext_we;

	// x0 and version 0 start out committed
	function automatic logic reset_ready(input int t);
		phys_tag_t tag;
		tag = phys_tag_t'(t[phys_tag_w-1:0]);
		return (tag.arch == '0) || (tag.version == '0);
	endfunction

	always_comb begin
		for (int i = 0; i < jal_dp; i++) begin
			rs1_data[i] = regs[rs1_tags[i]];
			rs1_ready[i] = wb_log[rs1_tags[i]];
		end
	end

	// ----------------------------------------
	// Write ports
	// ----------------------------------------
	assign exe_we = wb_valid & (wb_tag.arch != '0);
	assign ext_we = ext_wb_valid & (ext_wb_tag.arch != '0);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int t = 0; t < phys_cnt; t++) begin
				regs[t] <= '0;
				wb_log[t] <= reset_ready(t);
			end
		end else begin
			if (ext_we) begin
				regs[ext_wb_tag] <= ext_wb_data;
				wb_log[ext_wb_tag] <= 1'b1;
			end
			// Execute write last so it wins a tag clash
			if (exe_we) begin
				regs[wb_tag] <= wb_data;
				wb_log[wb_tag] <= 1'b1;
			end
		end
	end

endmodule

// File: source/jal_unit.sv
module jal_unit import rename_pkg::*, jal_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic dispatch_valid,
	input  jal_info_t dispatch_info,
	output logic credit_return,
	input  logic ext_wb_valid,
	input  phys_tag_t ext_wb_tag,
	input  logic [xlen-1:0] ext_wb_data,
	output logic result_valid,
	output jal_result_t result
);

	logic [jal_dp-1:0] entry_valid;
	jal_info_t entries [jal_dp];
	logic pop;
	logic [jal_idx_w-1:0] pop_index;
	phys_tag_t rs1_tags [jal_dp];
	logic [xlen-1:0] rs1_data [jal_dp];
	logic [jal_dp-1:0] rs1_ready;
	logic exeparam_valid;
	jal_exeparam_t exeparam;

	issue_buffer #(
		.payload_t(jal_info_t),
		.depth(jal_dp)
	) u_buffer (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_info(dispatch_info),
		.credit_return(credit_return),
		.pop(pop),
		.pop_index(pop_index),
		.entry_valid(entry_valid),
		.entries(entries)
	);

	jal_issue u_issue (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.entry_valid(entry_valid),
		.entries(entries),
		.pop(pop),
		.pop_index(pop_index),
		.rs1_tags(rs1_tags),
		.rs1_data(rs1_data),
		.rs1_ready(rs1_ready),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam)
	);

	jal_execute u_execute (
		.CLK(CLK),
		.rst_n(rst_n),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.result_valid(result_valid),
		.result(result)
	);

	// Link value goes straight back as the write-back
	phy_regfile u_regfile (
		.CLK(CLK),
		.rst_n(rst_n),
		.rs1_tags(rs1_tags),
		.rs1_data(rs1_data),
		.rs1_ready(rs1_ready),
		.wb_valid(result_valid),
		.wb_tag(result.rd),
		.wb_data(result.link),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb_tag(ext_wb_tag),
		.ext_wb_data(ext_wb_data)
	);

endmodule

// File: testbench/tb_jal_unit.sv
module tb_jal_unit import rename_pkg::*, jal_pkg::*; ();

	typedef struct packed {
		logic jalr;
		logic [xlen-1:0] pc;   // Zero draws a random pc
		logic rvc;
		phys_tag_t rd;
		phys_tag_t rs1;
		int wb_dly;   // Cycles after dispatch, -1 for none
		logic [xlen-1:0] wb_val;
		logic kill;   // Sent right before the flush
	} row_t;

	localparam int n_rows = 12;

	row_t rows [n_rows] = '{
		'{1'b0, 64'h1000, 1'b0, {5'd1, 2'd1}, {5'd0, 2'd0}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h1010, 1'b0, {5'd2, 2'd1}, {5'd10, 2'd1}, 12, 64'h8001, 1'b0},
		'{1'b0, 64'h0, 1'b1, {5'd3, 2'd1}, {5'd0, 2'd0}, -1, 64'h0, 1'b0},
		'{1'b0, 64'h2002, 1'b1, {5'd4, 2'd1}, {5'd0, 2'd0}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h2100, 1'b1, {5'd5, 2'd1}, {5'd4, 2'd1}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h3000, 1'b0, {5'd6, 2'd1}, {5'd0, 2'd2}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h0, 1'b0, {5'd7, 2'd2}, {5'd11, 2'd0}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h4000, 1'b0, {5'd8, 2'd1}, {5'd12, 2'd3}, 3, 64'hdead_beef_0000_1235, 1'b0},
		'{1'b0, 64'hffff_ffff_ffff_fffc, 1'b0, {5'd9, 2'd1}, {5'd0, 2'd0}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h5000, 1'b1, {5'd13, 2'd1}, {5'd3, 2'd1}, -1, 64'h0, 1'b0},
		'{1'b1, 64'h6000, 1'b0, {5'd14, 2'd1}, {5'd15, 2'd2}, 4, 64'h7001, 1'b1},
		'{1'b1, 64'h6004, 1'b0, {5'd16, 2'd1}, {5'd17, 2'd3}, 4, 64'h7003, 1'b1}
	};

	logic CLK;
	logic rst_n;
	logic flush;
	logic dispatch_valid;
	jal_info_t dispatch_info;
	logic credit_return;
	logic ext_wb_valid;
	phys_tag_t ext_wb_tag;
	logic [xlen-1:0] ext_wb_data;
	logic result_valid;
	jal_result_t result;

	logic [xlen-1:0] pc_of [n_rows];
	int row_of_tag [phys_cnt] = '{default: -1};
	int disp_cyc [n_rows] = '{default: -1};
	int wb_at [n_rows];
	int seq [n_rows];
	logic got [n_rows] = '{default: 1'b0};
	logic wb_done [n_rows] = '{default: 1'b0};
	logic dispatched = 1'b0;
	int cyc = 0;
	int spent = 0;
	int returned = 0;
	int nres = 0;
	int errs = 0;
	int mon_errs = 0;

	jal_unit uut (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_info(dispatch_info),
		.credit_return(credit_return),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb_tag(ext_wb_tag),
		.ext_wb_data(ext_wb_data),
		.result_valid(result_valid),
		.result(result)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) cyc <= cyc + 1;

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	function automatic logic [xlen-1:0] exp_link(input int r);
		return pc_of[r] + (rows[r].rvc ? xlen'(2) : xlen'(4));
	endfunction

	// Earlier row whose rd feeds this rs1
	function automatic int producer(input int r);
		int p;
		p = -1;
		for (int j = 0; j < r; j++) begin
			if (rows[j].rd == rows[r].rs1) p = j;
		end
		return p;
	endfunction

	function automatic logic [xlen-1:0] src_value(input int r);
		int p;
		p = producer(r);
		if (p >= 0) return exp_link(p);
		if (rows[r].wb_dly >= 0) return rows[r].wb_val;
		return '0;   // x0 or version 0
	endfunction

	function int credit_count();
		return jal_dp - spent + returned;
	endfunction

	// ----------------------------------------
	// Drivers
	// ----------------------------------------
	task automatic dispatch_row(input int r);
		while (credit_count() == 0) begin
			@(posedge CLK);
			#1;
		end
		dispatch_info.is_jal = ~rows[r].jalr;
		dispatch_info.is_jalr = rows[r].jalr;
		dispatch_info.pc = pc_of[r];
		dispatch_info.rd = rows[r].rd;
		dispatch_info.rs1 = rows[r].rs1;
		dispatch_info.is_rvc = rows[r].rvc;
		dispatch_valid = 1'b1;
		spent++;
		dispatched = 1'b1;
		disp_cyc[r] = cyc;
		@(posedge CLK);
		#1;
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_credits(input int limit);
		int n;
		n = 0;
		while (credit_count() != jal_dp && n < limit) begin
			@(posedge CLK);
			#1;
			n++;
		end
	endtask

	// External write-back, one per cycle, oldest due row first
	initial begin
		int due;
		ext_wb_valid = 1'b0;
		ext_wb_tag = '0;
		ext_wb_data = '0;
		forever begin
			@(posedge CLK);
			#1;
			due = -1;
			for (int r = n_rows - 1; r >= 0; r--) begin
				if (disp_cyc[r] >= 0 && rows[r].wb_dly >= 0 && !wb_done[r]
					&& cyc >= disp_cyc[r] + rows[r].wb_dly) due = r;
			end
			ext_wb_valid = (due >= 0);
			if (due >= 0) begin
				ext_wb_tag = rows[due].rs1;
				ext_wb_data = rows[due].wb_val;
				wb_done[due] = 1'b1;
				wb_at[due] = cyc;
			end
		end
	end

	// ----------------------------------------
	// Monitor, sampled mid-cycle
	// ----------------------------------------
	always @(negedge CLK) begin : monitor
		int r;
		int p;
		logic [xlen-1:0] exp_t;
		if (rst_n) begin
			if (credit_return) returned++;
			if (!dispatched) begin
				assert (!result_valid) else begin
					mon_errs++;
					$display("[ERROR] %0t result_valid: expected 0, got %b", $time, result_valid);
				end
				assert (!credit_return) else begin
					mon_errs++;
					$display("[ERROR] %0t credit_return: expected 0, got %b", $time, credit_return);
				end
			end
			assert (credit_count() >= 0 && credit_count() <= jal_dp) else begin
				mon_errs++;
				$display("Credit count left its range at %0t: %0d", $time, credit_count());
			end
			if (result_valid) begin
				r = row_of_tag[result.rd];
				assert (r >= 0) else begin
					mon_errs++;
					$display("Result at %0t carries an unknown rd tag %0h", $time, result.rd);
				end
				if (r >= 0) begin
					assert (!rows[r].kill) else begin
						mon_errs++;
						$display("Row %0d was flushed but still produced a result", r);
					end
					assert (!got[r]) else begin
						mon_errs++;
						$display("Row %0d produced a second result", r);
					end
					got[r] = 1'b1;
					seq[r] = nres;
					nres++;
					assert (result.link == exp_link(r)) else begin
						mon_errs++;
						$display("[ERROR] %0t result.link: expected %h, got %h", $time,
							exp_link(r), result.link);
					end
					assert (result.redirect == rows[r].jalr) else begin
						mon_errs++;
						$display("[ERROR] %0t result.redirect: expected %b, got %b", $time,
							rows[r].jalr, result.redirect);
					end
					if (rows[r].jalr) begin
						exp_t = src_value(r);
						exp_t[0] = 1'b0;
						assert (result.target == exp_t) else begin
							mon_errs++;
							$display("[ERROR] %0t result.target: expected %h, got %h", $time,
								exp_t, result.target);
						end
						p = producer(r);
						if (p >= 0) begin
							assert (got[p]) else begin
								mon_errs++;
								$display("Row %0d issued before its producer row %0d", r, p);
							end
						end
						if (rows[r].wb_dly >= 0) begin
							assert (wb_done[r]) else begin
								mon_errs++;
								$display("Row %0d issued before its rs1 write-back", r);
							end
						end
					end
				end
			end
		end
	end

	// ----------------------------------------
	// Sequence
	// ----------------------------------------
	initial begin
		logic [63:0] state;
		int n_live;
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_info = '0;
		state = 64'd46;
		n_live = 0;
		for (int r = 0; r < n_rows; r++) begin
			if (rows[r].pc == '0) begin
				state = xorshift64(state);
				pc_of[r] = {state[63:1], 1'b0};
			end else begin
				pc_of[r] = rows[r].pc;
			end
			row_of_tag[rows[r].rd] = r;
			if (!rows[r].kill) n_live++;
		end
		repeat (3) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		repeat (3) @(posedge CLK);   // Idle window after reset
		#1;

		for (int r = 0; r < n_rows; r++) begin
			if (!rows[r].kill) dispatch_row(r);
		end
		while (nres < n_live) begin
			@(posedge CLK);
			#1;
		end
		wait_credits(20);
		assert (credit_count() == jal_dp) else begin
			errs++;
			$display("[ERROR] %0t credits: expected %0d, got %0d", $time, jal_dp, credit_count());
		end

		// Blocked rows, then flush them
		for (int r = 0; r < n_rows; r++) begin
			if (rows[r].kill) dispatch_row(r);
		end
		flush = 1'b1;
		@(posedge CLK);
		#1;
		flush = 1'b0;
		wait_credits(20);
		assert (credit_count() == jal_dp) else begin
			errs++;
			$display("Credits did not come back after the flush, %0d held", credit_count());
		end
		repeat (10) @(posedge CLK);

		for (int r = 0; r < n_rows; r++) begin
			assert (got[r] == !rows[r].kill) else begin
				errs++;
				$display("Row %0d result count is wrong, result seen: %b", r, got[r]);
			end
			// Younger jal passes a jalr still waiting on rs1
			if (rows[r].jalr && rows[r].wb_dly >= 0 && got[r] && wb_done[r]) begin
				for (int k = r + 1; k < n_rows; k++) begin
					if (!rows[k].jalr && got[k] && disp_cyc[k] + 5 < wb_at[r]) begin
						assert (seq[k] < seq[r]) else begin
							errs++;
							$display("Jal row %0d did not finish ahead of blocked row %0d", k, r);
						end
					end
				end
			end
		end

		$display("Errors: %0d (monitor %0d, sequence %0d)", errs + mon_errs, mon_errs, errs);
		if (errs + mon_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(n_rows * 40 * 10);
		$display("Watchdog expired before all results and credits arrived");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: filelist.f
source/rename_pkg.sv
source/jal_pkg.sv
source/issue_buffer.sv
source/jal_issue.sv
source/jal_execute.sv
source/phy_regfile.sv
source/jal_unit.sv
testbench/tb_jal_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_jal_unit -f filelist.f -o tb_jal_unit \
	|| { echo "Build failed"; exit 1; }
out="$(./obj_dir/tb_jal_unit)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1
